// File: imuldiv.f
src/imuldiv_pkg.sv
src/imuldiv_iter_ctrl.sv
src/imuldiv_mul_dpath.sv
src/imuldiv_div_dpath.sv
src/imuldiv_iterative.sv
bench/imuldiv_asserts.sv
bench/imuldiv_tb.sv

// File: Makefile
# Verilator build and run for the iterative multiply/divide unit

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := imuldiv_tb
FILELIST := imuldiv.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^>>> PASS$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/imuldiv_vectors.txt
// columns (hex): fn a b expected resp_delay; fn 0 mul, 1 div, 2 divu
// expected is the 64-bit product, or {rem, quot} for divides; fn ff ends the list
0 00000000 00000000 0000000000000000 0
0 00000007 00000006 000000000000002a 3
0 fffffffd 00000005 fffffffffffffff1 1
0 00003039 fffffffe ffffffffffff9f8e 7
0 ffffffff ffffffff 0000000000000001 2
0 80000000 00000001 ffffffff80000000 0
0 80000000 80000000 4000000000000000 5
0 80000000 ffffffff 0000000080000000 4
0 7fffffff 7fffffff 3fffffff00000001 6
0 00010000 fffe0000 fffffffe00000000 1
0 7fffffff 80000000 c000000080000000 3
1 00000064 00000007 000000020000000e 2
1 ffffff9c 00000007 fffffffefffffff2 0
1 00000064 fffffff9 00000002fffffff2 7
1 ffffff9c fffffff9 fffffffe0000000e 1
1 80000000 ffffffff 0000000080000000 4
1 80000000 00000002 00000000c0000000 6
1 00001234 00000000 00001234ffffffff 2
1 fffffffb 00000000 fffffffb00000001 0
1 00000007 0000000a 0000000700000000 5
1 ffffffff 80000000 ffffffff00000000 3
2 00000064 00000007 000000020000000e 1
2 ffffffff 00000002 000000017fffffff 4
2 80000000 ffffffff 8000000000000000 0
2 fffffffe ffffffff fffffffe00000000 7
2 ffffffff ffffffff 0000000000000001 2
2 deadbeef 00000000 deadbeefffffffff 6
2 00000000 00000000 00000000ffffffff 3
2 80000001 00000010 0000000108000000 5
ff 0 0 0 0

// File: bench/imuldiv_tb.sv
// ----------------------------------------
// vector-driven testbench for the iterative
// multiply/divide unit with back-pressure
// ----------------------------------------

`timescale 1ns/1ps

module imuldiv_tb
  import imuldiv_pkg::*;
();

  localparam int          MAX_VECTORS   = 64;
  localparam int          WORDS_PER_VEC = 5;
  localparam logic [63:0] END_MARK      = 64'hff;

  logic            clk;
  logic            reset;
  logic [FN_W-1:0] req_fn;
  logic [XLEN-1:0] req_a;
  logic [XLEN-1:0] req_b;
  logic            req_val;
  logic            req_rdy;
  imuldiv_result_u resp_result;
  logic            resp_val;
  logic            resp_rdy;

  // five words per line: fn, a, b, expected, delay
  logic [63:0] vec_mem [0:MAX_VECTORS*WORDS_PER_VEC-1];
  int          num_vectors;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  imuldiv_iterative DUT (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // watchdog, limit set once the vector count is known
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the unit stopped responding after %0d cycles", cycle_count);
      abort_run();
    end
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_product(string name, imuldiv_result_u expected,
                               imuldiv_result_u actual);
    if (actual.product !== expected.product) begin
      $display("Error %s: product expected %h, actual %h", name, expected.product,
               actual.product);
      abort_run();
    end
  endtask

  // quotient and remainder reported on their own
  task automatic check_divrem(string name, imuldiv_result_u expected,
                              imuldiv_result_u actual);
    if (actual.divrem.quot !== expected.divrem.quot) begin
      $display("Error %s: quot expected %h, actual %h", name, expected.divrem.quot,
               actual.divrem.quot);
      abort_run();
    end
    if (actual.divrem.rem !== expected.divrem.rem) begin
      $display("Error %s: rem expected %h, actual %h", name, expected.divrem.rem,
               actual.divrem.rem);
      abort_run();
    end
  endtask

  task automatic check_latency(string name, int expected, int actual);
    if (actual != expected) begin
      $display("Error %s: latency expected %0d, actual %0d", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_level(string name, string what, logic expected, logic actual);
    if (actual !== expected) begin
      $display("Error %s: %s expected %b, actual %b", name, what, expected, actual);
      abort_run();
    end
  endtask

  function automatic string sign_tag(logic [XLEN-1:0] v);
    if (v == '0) return "zero";
    return v[XLEN-1] ? "neg" : "pos";
  endfunction

  // e.g. mul_neg_pos_3
  function automatic string test_name(logic [FN_W-1:0] fn, logic [XLEN-1:0] a,
                                      logic [XLEN-1:0] b, int idx);
    string op;
    op = (fn == FN_MUL) ? "mul" : ((fn == FN_DIV) ? "div" : "divu");
    return $sformatf("%s_%s_%s_%0d", op, sign_tag(a), sign_tag(b), idx);
  endfunction

  // ----------------------------------------
  // one request/response exchange
  // ----------------------------------------
  // entered and left on a falling edge
  task automatic run_vector(int idx);
    int              base;
    int              delay;
    int              edges;
    logic [FN_W-1:0] fn;
    imuldiv_result_u expected;
    string           name;
    base     = idx * WORDS_PER_VEC;
    fn       = vec_mem[base][FN_W-1:0];
    expected = vec_mem[base+3];
    delay    = int'(vec_mem[base+4]);
    name     = test_name(fn, vec_mem[base+1][XLEN-1:0], vec_mem[base+2][XLEN-1:0], idx);
    // random idle gap before the request
    repeat ($urandom_range(0, 3)) @(negedge clk);
    req_fn  = fn;
    req_a   = vec_mem[base+1][XLEN-1:0];
    req_b   = vec_mem[base+2][XLEN-1:0];
    req_val = 1'b1;
    while (!req_rdy) @(negedge clk);
    // accepting edge passes here; scramble operands, the unit holds its own copy
    @(negedge clk);
    req_val = 1'b0;
    req_a   = $urandom();
    req_b   = $urandom();
    edges   = 1;
    while (!resp_val) begin
      @(negedge clk);
      edges++;
    end
    check_latency(name, NUM_STEPS + 1, edges);
    // stall the response and watch it hold
    for (int i = 0; i <= delay; i++) begin
      if (i > 0) @(negedge clk);
      check_level(name, "resp_val", 1'b1, resp_val);
      check_level(name, "req_rdy", 1'b0, req_rdy);
      if (fn == FN_MUL) check_product(name, expected, resp_result);
      else check_divrem(name, expected, resp_result);
    end
    resp_rdy = 1'b1;
    @(negedge clk);
    resp_rdy = 1'b0;
    // back in IDLE after the transfer
    check_level(name, "resp_val", 1'b0, resp_val);
    check_level(name, "req_rdy", 1'b1, req_rdy);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(32'h2d7c7eef));
    reset    = 1'b1;
    req_fn   = FN_MUL;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    $readmemh("bench/imuldiv_vectors.txt", vec_mem);
    num_vectors = 0;
    while (num_vectors < MAX_VECTORS && vec_mem[num_vectors*WORDS_PER_VEC] != END_MARK) begin
      num_vectors++;
    end
    if (num_vectors == MAX_VECTORS || num_vectors == 0) begin
      $display("vector file is missing, empty or has no end line");
      abort_run();
    end
    cycle_limit = num_vectors * (NUM_STEPS + 1 + 7 + 4) + 100;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // idle before any request
    check_level("reset", "req_rdy", 1'b1, req_rdy);
    check_level("reset", "resp_val", 1'b0, resp_val);
    for (int i = 0; i < num_vectors; i++) begin
      run_vector(i);
    end
    if (DUT.u_asserts.error_count != 0) begin
      $display("assertions on the handshake failed during the run");
      abort_run();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// File: bench/imuldiv_asserts.sv
// ----------------------------------------
// bound checks on handshake and reset
// ----------------------------------------

`timescale 1ns/1ps

module imuldiv_asserts
  import imuldiv_pkg::*;
(
  input logic            clk,
  input logic            reset,
  input logic            req_val,
  input logic            req_rdy,
  input logic            resp_val,
  input logic            resp_rdy,
  input imuldiv_result_u resp_result
);

  // failures seen so far, read by the testbench at the end
  int error_count = 0;
  // cycles left in the current calculation
  int busy_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_cnt <= 0;
    end else if (req_val && req_rdy) begin
      busy_cnt <= NUM_STEPS;
    end else if (busy_cnt != 0) begin
      busy_cnt <= busy_cnt - 1;
    end
  end

  // ----------------------------------------
  // handshake
  // ----------------------------------------
  // one side ready at a time, the FSM is either idle or done
  rdy_val_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val))
    else begin
      error_count++;
      $error("req_rdy and resp_val were high in the same cycle");
    end

  // a stalled response keeps its word and its valid
  resp_held: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else begin
      error_count++;
      $error("response changed while stalled by resp_rdy");
    end

  // no early response while the steps run
  no_early_resp: assert property (@(posedge clk) disable iff (reset)
    (busy_cnt != 0) |-> !resp_val)
    else begin
      error_count++;
      $error("resp_val rose before all steps had run");
    end

  // ----------------------------------------
  // reset
  // ----------------------------------------
  idle_after_reset: assert property (@(posedge clk)
    $fell(reset) |-> (req_rdy && !resp_val))
    else begin
      error_count++;
      $error("unit not idle in the first cycle after reset");
    end

endmodule

bind imuldiv_iterative imuldiv_asserts u_asserts (
  .clk         (clk),
  .reset       (reset),
  .req_val     (req_val),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

// File: src/imuldiv_iterative.sv
// ----------------------------------------
// iterative multiply/divide unit top level
// ----------------------------------------

`timescale 1ns/1ps

module imuldiv_iterative
  import imuldiv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,

  // request side, val/rdy
  input  logic [FN_W-1:0] req_fn,
  input  logic [XLEN-1:0] req_a,
  input  logic [XLEN-1:0] req_b,
  input  logic            req_val,
  output logic            req_rdy,

  // response side, val/rdy
  output imuldiv_result_u resp_result,
  output logic            resp_val,
  input  logic            resp_rdy
);

  // strobes and latched operation
  logic load;
  logic step;
  logic op_div;
  logic op_signed;

  // per-datapath results
  imuldiv_result_u mul_result;
  imuldiv_result_u div_result;

  // ----------------------------------------
  // control
  // ----------------------------------------
  imuldiv_iter_ctrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_fn    (req_fn),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .load      (load),
    .step      (step),
    .op_div    (op_div),
    .op_signed (op_signed)
  );

  // ----------------------------------------
  // datapaths
  // ----------------------------------------
  // both capture on every load, only one result is used
  imuldiv_mul_dpath mul_dpath (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .step   (step),
    .req_a  (req_a),
    .req_b  (req_b),
    .result (mul_result)
  );

  imuldiv_div_dpath div_dpath (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .step      (step),
    .op_signed (op_signed),
    .req_a     (req_a),
    .req_b     (req_b),
    .result    (div_result)
  );

  // response word steered by the latched operation
  assign resp_result = op_div ? div_result : mul_result;

endmodule

// File: src/imuldiv_div_dpath.sv
// ----------------------------------------
// restoring divide datapath with signed or
// unsigned quotient/remainder fix-up
// ----------------------------------------

`timescale 1ns/1ps

module imuldiv_div_dpath
  import imuldiv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,

  // strobes and operation level from the controller
  input  logic            load,
  input  logic            step,
  input  logic            op_signed,

  // dividend and divisor
  input  logic [XLEN-1:0] req_a,
  input  logic [XLEN-1:0] req_b,

  // remainder and quotient
  output imuldiv_result_u result
);

  // saved signs, only set for signed divide
  logic sign_a_reg;
  logic sign_b_reg;

  // upper half partial remainder, lower half dividend then quotient
  logic [2*XLEN-1:0] rq_reg;
  logic [XLEN-1:0]   div_reg;

  logic            neg_a;
  logic            neg_b;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;

  // partial remainder after the shift, one extra bit for the carry out
  logic [XLEN:0]   partial;
  // trial difference, top bit is the borrow
  logic [XLEN+1:0] diff;
  logic            fits;

  logic [XLEN-1:0] quot_mag;
  logic [XLEN-1:0] rem_mag;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------
  // unsigned divide takes the operands as they are
  assign neg_a = op_signed & req_a[XLEN-1];
  assign neg_b = op_signed & req_b[XLEN-1];
  assign a_mag = neg_a ? (~req_a + 1'b1) : req_a;
  assign b_mag = neg_b ? (~req_b + 1'b1) : req_b;

  // ----------------------------------------
  // one restoring step
  // ----------------------------------------
  // shift left one bit: remainder picks up the next dividend bit
  assign partial = rq_reg[2*XLEN-1:XLEN-1];
  assign diff    = {1'b0, partial} - {2'b00, div_reg};
  // no borrow means the divisor goes in
  assign fits    = ~diff[XLEN+1];

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (load) begin
      sign_a_reg <= neg_a;
      sign_b_reg <= neg_b;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rq_reg  <= {{XLEN{1'b0}}, a_mag};
      div_reg <= b_mag;
    end else if (step) begin
      if (fits) begin
        // keep the difference and set the new quotient bit
        rq_reg <= {diff[XLEN-1:0], rq_reg[XLEN-2:0], 1'b1};
      end else begin
        // restore: plain shift, quotient bit stays zero
        rq_reg <= {partial[XLEN-1:0], rq_reg[XLEN-2:0], 1'b0};
      end
    end
  end

  // ----------------------------------------
  // sign fix
  // ----------------------------------------
  // a zero divisor leaves all ones in the quotient and the dividend in the remainder
  assign quot_mag = rq_reg[XLEN-1:0];
  assign rem_mag  = rq_reg[2*XLEN-1:XLEN];

  always_comb begin
    // quotient negative when the signs differ, 0x80000000 / -1 wraps back
    result.divrem.quot = (sign_a_reg ^ sign_b_reg) ? (~quot_mag + 1'b1) : quot_mag;
    // remainder follows the dividend
    result.divrem.rem  = sign_a_reg ? (~rem_mag + 1'b1) : rem_mag;
  end

endmodule

// File: src/imuldiv_mul_dpath.sv
// ----------------------------------------
// shift-and-add signed multiply datapath
// ----------------------------------------

`timescale 1ns/1ps

module imuldiv_mul_dpath
  import imuldiv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,

  // strobes from the controller
  input  logic            load,
  input  logic            step,

  // operands
  input  logic [XLEN-1:0] req_a,
  input  logic [XLEN-1:0] req_b,

  // signed product
  output imuldiv_result_u result
);

  // saved operand signs
  logic sign_a_reg;
  logic sign_b_reg;

  // multiplicand grows left, multiplier drains right
  logic [2*XLEN-1:0] a_reg;
  logic [XLEN-1:0]   b_reg;
  logic [2*XLEN-1:0] acc_reg;

  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic [2*XLEN-1:0] acc_next;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------
  // most negative input maps to 2^31, still fits unsigned
  assign a_mag = req_a[XLEN-1] ? (~req_a + 1'b1) : req_a;
  assign b_mag = req_b[XLEN-1] ? (~req_b + 1'b1) : req_b;

  // add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = b_reg[0] ? (acc_reg + a_reg) : acc_reg;

  // ----------------------------------------
  // sign flags and accumulator
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
      acc_reg    <= '0;
    end else if (load) begin
      sign_a_reg <= req_a[XLEN-1];
      sign_b_reg <= req_b[XLEN-1];
      acc_reg    <= '0;
    end else if (step) begin
      acc_reg    <= acc_next;
    end
  end

  // ----------------------------------------
  // operand shift registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      // zero-extend multiplicand to the full product width
      a_reg <= {{XLEN{1'b0}}, a_mag};
      b_reg <= b_mag;
    end else if (step) begin
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // ----------------------------------------
  // sign fix
  // ----------------------------------------
  // negative product when exactly one operand was negative
  always_comb begin
    result.product = (sign_a_reg ^ sign_b_reg) ? (~acc_reg + 1'b1) : acc_reg;
  end

endmodule

// File: src/imuldiv_iter_ctrl.sv
// ----------------------------------------
// IDLE/CALC/DONE controller with step
// counter and latched operation flags
// ----------------------------------------

`timescale 1ns/1ps

module imuldiv_iter_ctrl
  import imuldiv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,

  // request side
  input  logic [FN_W-1:0] req_fn,
  input  logic            req_val,
  output logic            req_rdy,

  // response side
  output logic            resp_val,
  input  logic            resp_rdy,

  // datapath strobes and operation levels
  output logic            load,
  output logic            step,
  output logic            op_div,
  output logic            op_signed
);

  logic [ST_W-1:0]  state;
  logic [CNT_W-1:0] count;

  logic req_go;
  logic resp_go;
  logic last_step;

  // signedness of the incoming and of the running operation
  logic fn_signed;
  logic op_signed_reg;

  // transfers on either side
  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  // final CALC cycle
  assign last_step = (count == CNT_W'(NUM_STEPS - 1));

  // operands are captured in the accepting cycle
  assign load = req_go;

  // signed multiply and signed divide
  assign fn_signed = (req_fn == FN_MUL) || (req_fn == FN_DIV);

  // the divide datapath takes its magnitudes in the accepting cycle,
  // so the level follows req_fn while idle and the latched copy after
  assign op_signed = (state == ST_IDLE) ? fn_signed : op_signed_reg;

  // ----------------------------------------
  // state and counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= ST_IDLE;
      count         <= '0;
      op_div        <= 1'b0;
      op_signed_reg <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_go) begin
            state         <= ST_CALC;
            count         <= '0;
            // remember the operation for steering and sign fix
            op_div        <= (req_fn == FN_DIV) || (req_fn == FN_DIVU);
            op_signed_reg <= fn_signed;
          end
        end
        ST_CALC: begin
          // exactly NUM_STEPS cycles here
          if (last_step) begin
            state <= ST_DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        ST_DONE: begin
          // hold until the response is taken
          if (resp_go) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // outputs decoded from state
  // ----------------------------------------
  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    step     = 1'b0;
    case (state)
      ST_IDLE: req_rdy  = 1'b1;
      ST_CALC: step     = 1'b1;
      ST_DONE: resp_val = 1'b1;
      default: req_rdy  = 1'b0;
    endcase
  end

endmodule

// File: src/imuldiv_pkg.sv
// ----------------------------------------
// shared constants and result type for the
// iterative multiply/divide unit
// ----------------------------------------

package imuldiv_pkg;

  // ----------------------------------------
  // operation field
  // ----------------------------------------
  localparam int FN_W = 2;

  // signed multiply, full 64-bit product
  localparam logic [FN_W-1:0] FN_MUL = 2'd0;
  // signed divide, quotient and remainder
  localparam logic [FN_W-1:0] FN_DIV = 2'd1;
  // unsigned divide
  localparam logic [FN_W-1:0] FN_DIVU = 2'd2;

  // ----------------------------------------
  // widths and iteration count
  // ----------------------------------------
  localparam int XLEN = 32;
  // one step per operand bit
  localparam int NUM_STEPS = 32;
  // step counter width
  localparam int CNT_W = $clog2(NUM_STEPS);

  // control FSM encoding
  localparam int ST_W = 2;
  localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
  localparam logic [ST_W-1:0] ST_CALC = 2'd1;
  localparam logic [ST_W-1:0] ST_DONE = 2'd2;

  // ----------------------------------------
  // response word
  // ----------------------------------------
  // multiply reads it as one product, divide as rem/quot halves
  typedef union packed {
    logic signed [2*XLEN-1:0] product;
    struct packed {
      logic [XLEN-1:0] rem;
      logic [XLEN-1:0] quot;
    } divrem;
  } imuldiv_result_u;

endpackage
